/* common/coh_params.svh */
`ifndef COH_PARAMS_SVH
`define COH_PARAMS_SVH

`define COH_CACHE_NUM 4
`define COH_ID_W      2
`define COH_ADDR_W    32
`define COH_OPC_W     4

// opcode, ta, ra, index from the top down
`define COH_MSG_W     (`COH_OPC_W + 2 * `COH_ID_W + `COH_ADDR_W)

`define COH_IDX_LSB   0
`define COH_RA_LSB    (`COH_IDX_LSB + `COH_ADDR_W)
`define COH_TA_LSB    (`COH_RA_LSB + `COH_ID_W)
`define COH_OPC_LSB   (`COH_TA_LSB + `COH_ID_W)

// one outstanding request per cache at most
`define COH_Q_DEPTH   `COH_CACHE_NUM

`endif

/* common/coh_pkg.sv */
`include "coh_params.svh"

package coh_pkg;

    // message opcodes, bit 2 marks a request
    localparam logic [`COH_OPC_W-1:0] opc_wr_ack    = 4'b0000;
    localparam logic [`COH_OPC_W-1:0] opc_rd_ack    = 4'b0010;
    localparam logic [`COH_OPC_W-1:0] opc_share_ack = 4'b0011;
    localparam logic [`COH_OPC_W-1:0] opc_wr_req    = 4'b0100;
    localparam logic [`COH_OPC_W-1:0] opc_rd_req    = 4'b0101;

    // directory status, other codes read as clean
    localparam logic [2:0] st_absent = 3'b000;
    localparam logic [2:0] st_clean  = 3'b001;
    localparam logic [2:0] st_dirty  = 3'b010;

    localparam logic [2:0] cmd_lookup     = 3'b001;
    localparam logic [2:0] cmd_downgrade  = 3'b010;
    localparam logic [2:0] cmd_invalidate = 3'b011;

    localparam logic [1:0] fcmd_writeback = 2'b01;

endpackage

/* hw/msg_ctrl.sv */
`timescale 1ns/1ps
`include "coh_params.svh"

module msg_ctrl #(
    parameter int cache_id = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,

    output logic                   acc_req,
    input  logic                   acc_gnt,
    output logic [2:0]             acc_cmd,
    output logic [`COH_ADDR_W-1:0] acc_index,
    input  logic [2:0]             acc_status,

    output logic                   fetch_req,
    input  logic                   fetch_gnt,
    output logic [1:0]             fetch_cmd,
    output logic [`COH_ADDR_W-1:0] fetch_addr,
    input  logic                   fetch_done,

    output logic                   msg_req,
    input  logic                   msg_gnt,
    output logic [`COH_MSG_W-1:0]  msg,
    input  logic                   msg_in_valid,
    input  logic [`COH_MSG_W-1:0]  msg_in
);

    logic                  req_valid;
    logic [`COH_MSG_W-1:0] req_word;
    logic                  req_pop;

    snoop_req_queue #(
        .cache_id     (cache_id)
    ) u_req_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .msg_in_valid (msg_in_valid),
        .msg_in       (msg_in),
        .req_pop      (req_pop),
        .req_valid    (req_valid),
        .req_word     (req_word)
    );

    snoop_rsp_fsm #(
        .cache_id     (cache_id)
    ) u_rsp_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_word     (req_word),
        .req_pop      (req_pop),
        .acc_req      (acc_req),
        .acc_gnt      (acc_gnt),
        .acc_cmd      (acc_cmd),
        .acc_index    (acc_index),
        .acc_status   (acc_status),
        .fetch_req    (fetch_req),
        .fetch_gnt    (fetch_gnt),
        .fetch_cmd    (fetch_cmd),
        .fetch_addr   (fetch_addr),
        .fetch_done   (fetch_done),
        .msg_req      (msg_req),
        .msg_gnt      (msg_gnt),
        .msg          (msg)
    );

endmodule

/* run.sh */
#!/bin/sh
# build and run the msg_ctrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_msg_ctrl -o tb_msg_ctrl
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_msg_ctrl)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

/* snoop/snoop_req_queue.sv */
`timescale 1ns/1ps
`include "coh_params.svh"

module snoop_req_queue #(
    parameter int cache_id = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  msg_in_valid,
    input  logic [`COH_MSG_W-1:0] msg_in,
    input  logic                  req_pop,
    output logic                  req_valid,
    output logic [`COH_MSG_W-1:0] req_word
);

    localparam int ptr_w = $clog2(`COH_Q_DEPTH);
    localparam int cnt_w = $clog2(`COH_Q_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(`COH_Q_DEPTH - 1);
    localparam logic [cnt_w-1:0] full_cnt  = cnt_w'(`COH_Q_DEPTH);

    logic [`COH_MSG_W-1:0] mem [`COH_Q_DEPTH];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [cnt_w-1:0]      count;
    logic [`COH_OPC_W-1:0] in_opc;
    logic [`COH_ID_W-1:0]  in_ra;
    logic                  is_req;
    logic                  push;
    logic                  full;

    assign in_opc = msg_in[`COH_OPC_LSB +: `COH_OPC_W];
    assign in_ra  = msg_in[`COH_RA_LSB +: `COH_ID_W];
    assign is_req = (in_opc == coh_pkg::opc_rd_req) || (in_opc == coh_pkg::opc_wr_req);
    assign push   = msg_in_valid && is_req && (in_ra == cache_id[`COH_ID_W-1:0]);

    assign full      = (count == full_cnt);
    assign req_valid = (count != '0);
    assign req_word  = mem[rd_ptr]; // head of queue

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= msg_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            if (req_pop) begin
                rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, req_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // sender keeps one request per cache in flight
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) !(push && full)
    ) else $error("snoop queue written while full");

    // fsm pops only a request it has served
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n) !(req_pop && !req_valid)
    ) else $error("snoop queue popped while empty");

endmodule

/* snoop/snoop_rsp_fsm.sv */
`timescale 1ns/1ps
`include "coh_params.svh"

module snoop_rsp_fsm #(
    parameter int cache_id = 0
) (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   req_valid,
    input  logic [`COH_MSG_W-1:0]  req_word,
    output logic                   req_pop,

    output logic                   acc_req,
    input  logic                   acc_gnt,
    output logic [2:0]             acc_cmd,
    output logic [`COH_ADDR_W-1:0] acc_index,
    input  logic [2:0]             acc_status,

    output logic                   fetch_req,
    input  logic                   fetch_gnt,
    output logic [1:0]             fetch_cmd,
    output logic [`COH_ADDR_W-1:0] fetch_addr,
    input  logic                   fetch_done,

    output logic                   msg_req,
    input  logic                   msg_gnt,
    output logic [`COH_MSG_W-1:0]  msg
);

    localparam logic [2:0] s_idle    = 3'd0;
    localparam logic [2:0] s_lookup  = 3'd1;
    localparam logic [2:0] s_wb_req  = 3'd2;
    localparam logic [2:0] s_wb_wait = 3'd3;
    localparam logic [2:0] s_update  = 3'd4;
    localparam logic [2:0] s_send    = 3'd5;
    localparam logic [2:0] s_done    = 3'd6;

    logic [2:0]             state;
    logic [2:0]             state_nxt;
    logic [2:0]             status_q;
    logic [`COH_OPC_W-1:0]  req_opc;
    logic [`COH_ID_W-1:0]   req_ta;
    logic [`COH_ADDR_W-1:0] req_idx;
    logic [`COH_OPC_W-1:0]  rsp_opc;
    logic                   is_wr;
    logic                   acc_hs;
    logic                   fetch_hs;
    logic                   msg_hs;

    assign req_opc = req_word[`COH_OPC_LSB +: `COH_OPC_W];
    assign req_ta  = req_word[`COH_TA_LSB +: `COH_ID_W];
    assign req_idx = req_word[`COH_IDX_LSB +: `COH_ADDR_W];
    assign is_wr   = (req_opc == coh_pkg::opc_wr_req);

    assign acc_hs   = acc_req && acc_gnt;
    assign fetch_hs = fetch_req && fetch_gnt;
    assign msg_hs   = msg_req && msg_gnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            s_idle: begin
                if (req_valid) begin
                    state_nxt = s_lookup;
                end
            end
            s_lookup: begin
                if (acc_hs) begin
                    if (acc_status == coh_pkg::st_absent) begin
                        state_nxt = s_send;
                    end else if (acc_status == coh_pkg::st_dirty) begin
                        state_nxt = s_wb_req;
                    end else begin
                        state_nxt = s_update;
                    end
                end
            end
            s_wb_req:  if (fetch_hs) state_nxt = s_wb_wait;
            s_wb_wait: if (fetch_done) state_nxt = s_update;
            s_update:  if (acc_hs) state_nxt = s_send;
            s_send:    if (msg_hs) state_nxt = s_done;
            default:   state_nxt = s_idle; // s_done pops the head
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == s_lookup && acc_hs) begin
            status_q <= acc_status; // decides share ack
        end
    end

    always_comb begin
        if (is_wr) begin
            rsp_opc = coh_pkg::opc_wr_ack;
        end else if (status_q != coh_pkg::st_absent) begin
            rsp_opc = coh_pkg::opc_share_ack;
        end else begin
            rsp_opc = coh_pkg::opc_rd_ack;
        end
    end

    assign acc_req    = (state == s_lookup) || (state == s_update);
    assign acc_cmd    = (state != s_update) ? coh_pkg::cmd_lookup :
                        is_wr ? coh_pkg::cmd_invalidate : coh_pkg::cmd_downgrade;
    assign acc_index  = req_idx;
    assign fetch_req  = (state == s_wb_req);
    assign fetch_cmd  = coh_pkg::fcmd_writeback;
    assign fetch_addr = req_idx;
    assign msg_req    = (state == s_send);
    assign msg        = {rsp_opc, cache_id[`COH_ID_W-1:0], req_ta, req_idx}; // back to requester
    assign req_pop    = (state == s_done);

    // head stays queued until s_done pops it
    a_head_held: assert property (
        @(posedge clk) disable iff (!rst_n) (state != s_idle) |-> req_valid
    ) else $error("request in service left the queue");

    a_msg_stable: assert property (
        @(posedge clk) disable iff (!rst_n) msg_req && !msg_gnt |=> $stable(msg)
    ) else $error("response word changed while waiting for msg_gnt");

endmodule

/* tb.f */
+incdir+common
common/coh_pkg.sv
snoop/snoop_req_queue.sv
snoop/snoop_rsp_fsm.sv
hw/msg_ctrl.sv
testbench/tb_msg_ctrl.sv

/* testbench/tb_msg_ctrl.sv */
`timescale 1ns/1ps
`include "coh_params.svh"

module tb_msg_ctrl;

    localparam logic [`COH_ID_W-1:0] own_id     = 2'd1;
    localparam logic [5:0]           num_reqs   = 6'd60;
    localparam logic [11:0]          max_cycles = 12'd3000; // 60 requests, ~40 cycles each
    localparam logic [31:0]          seed       = 32'hc63d_2956;

    logic        clk       = 1'b0;
    logic        rst_n     = 1'b0;
    logic        rst_q     = 1'b0;
    logic [11:0] cycle_cnt = '0;

    logic [2:0]             acc_status   = '0;
    logic                   acc_gnt      = 1'b0;
    logic                   fetch_gnt    = 1'b0;
    logic                   fetch_done   = 1'b0;
    logic                   msg_gnt      = 1'b0;
    logic                   msg_in_valid = 1'b0;
    logic [`COH_MSG_W-1:0]  msg_in       = '0;
    logic                   acc_req;
    logic [2:0]             acc_cmd;
    logic [`COH_ADDR_W-1:0] acc_index;
    logic                   fetch_req;
    logic [1:0]             fetch_cmd;
    logic [`COH_ADDR_W-1:0] fetch_addr;
    logic                   msg_req;
    logic [`COH_MSG_W-1:0]  msg;

    logic [31:0]           rng        = seed;
    logic [31:0]           r;
    logic [31:0]           r_idx;
    logic [1:0]            acc_wait   = '0;
    logic [1:0]            fetch_wait = '0;
    logic [1:0]            msg_wait   = '0;
    logic [2:0]            done_wait  = '0;
    logic [`COH_ID_W-1:0]  req_ta;
    logic [`COH_ID_W-1:0]  noise_ra;
    logic [`COH_OPC_W-1:0] req_opc;
    logic [`COH_OPC_W-1:0] noise_opc;

    logic [`COH_MSG_W-1:0] exp_word [64] = '{default: '0};
    logic [2:0]            exp_status [64] = '{default: '0};
    logic [5:0]            sent_cnt [`COH_CACHE_NUM] = '{default: '0};
    logic [5:0]            done_cnt [`COH_CACHE_NUM] = '{default: '0};
    logic [5:0]            n_sent  = '0;
    logic [5:0]            n_done  = '0;
    logic                  looked  = 1'b0;
    logic                  updated = 1'b0;
    logic                  fetched = 1'b0;
    logic                  wb_done = 1'b0;

    logic [`COH_MSG_W-1:0]  head_word;
    logic [`COH_ID_W-1:0]   head_ta;
    logic [`COH_ADDR_W-1:0] head_idx;
    logic                   head_wr;
    logic [2:0]             head_status;
    logic                   exp_absent;
    logic                   exp_dirty;
    logic [2:0]             exp_acc_cmd;
    logic [`COH_OPC_W-1:0]  exp_rsp_opc;
    logic [`COH_MSG_W-1:0]  exp_rsp;

    msg_ctrl #(
        .cache_id     (1)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .acc_req      (acc_req),
        .acc_gnt      (acc_gnt),
        .acc_cmd      (acc_cmd),
        .acc_index    (acc_index),
        .acc_status   (acc_status),
        .fetch_req    (fetch_req),
        .fetch_gnt    (fetch_gnt),
        .fetch_cmd    (fetch_cmd),
        .fetch_addr   (fetch_addr),
        .fetch_done   (fetch_done),
        .msg_req      (msg_req),
        .msg_gnt      (msg_gnt),
        .msg          (msg),
        .msg_in_valid (msg_in_valid),
        .msg_in       (msg_in)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input string expected, input string actual);
        abort_run($sformatf("MISMATCH %s expected %s actual %s", test, expected, actual));
    endtask

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 12'd1;
        rst_q     <= rst_n;
        if (cycle_cnt == 12'd1) begin
            rst_n <= 1'b1; // low for two rising edges
        end
    end

    // head of the scoreboard and the response it must get
    assign head_word   = exp_word[n_done];
    assign head_ta     = head_word[`COH_TA_LSB +: `COH_ID_W];
    assign head_idx    = head_word[`COH_IDX_LSB +: `COH_ADDR_W];
    assign head_wr     = head_word[`COH_OPC_LSB +: `COH_OPC_W] == coh_pkg::opc_wr_req;
    assign head_status = exp_status[n_done];
    assign exp_absent  = head_status == coh_pkg::st_absent;
    assign exp_dirty   = head_status == coh_pkg::st_dirty;
    assign exp_acc_cmd = !looked ? coh_pkg::cmd_lookup :
                         head_wr ? coh_pkg::cmd_invalidate : coh_pkg::cmd_downgrade;
    assign exp_rsp_opc = head_wr ? coh_pkg::opc_wr_ack :
                         exp_absent ? coh_pkg::opc_rd_ack : coh_pkg::opc_share_ack;
    assign exp_rsp     = {exp_rsp_opc, own_id, head_ta, head_idx};

    // stimulus, directory, fetch and ring models
    always @(posedge clk) begin
        rng   = xorshift(rng);
        r     = rng;
        rng   = xorshift(rng);
        r_idx = rng;
        req_ta  = (r[5:4] == own_id) ? 2'd0 : r[5:4];
        req_opc = r[6] ? coh_pkg::opc_wr_req : coh_pkg::opc_rd_req;
        if (r[9] == 1'b0) begin
            noise_opc = r[8] ? coh_pkg::opc_rd_ack : coh_pkg::opc_wr_ack;
            noise_ra  = own_id;
        end else begin
            noise_opc = req_opc; // request for another cache
            noise_ra  = (r[20:19] == own_id) ? 2'd3 : r[20:19];
        end
        msg_in_valid <= 1'b0;
        fetch_done   <= 1'b0;
        if (rst_n) begin
            if (r[3:0] < 4'd3) begin
                msg_in_valid <= 1'b1;
                msg_in       <= {noise_opc, r[22:21], noise_ra, r_idx};
            end else if (r[3:0] < 4'd9 && n_sent != num_reqs &&
                         sent_cnt[req_ta] == done_cnt[req_ta]) begin
                msg_in_valid      <= 1'b1;
                msg_in            <= {req_opc, req_ta, own_id, r_idx};
                exp_word[n_sent]  <= {req_opc, req_ta, own_id, r_idx};
                n_sent            <= n_sent + 6'd1;
                sent_cnt[req_ta]  <= sent_cnt[req_ta] + 6'd1;
            end
            if (acc_gnt) begin
                acc_gnt  <= 1'b0;
                acc_wait <= r[14:13];
            end else if (acc_req) begin
                if (acc_wait == 2'd0) begin
                    acc_gnt    <= 1'b1;
                    acc_status <= r[12:10]; // codes above dirty read as clean
                end else begin
                    acc_wait <= acc_wait - 2'd1;
                end
            end
            if (fetch_gnt) begin
                fetch_gnt  <= 1'b0;
                fetch_wait <= r[24:23];
                done_wait  <= 3'd1 + {1'b0, r[18:17]};
            end else if (fetch_req) begin
                if (fetch_wait == 2'd0) begin
                    fetch_gnt <= 1'b1;
                end else begin
                    fetch_wait <= fetch_wait - 2'd1;
                end
            end else if (done_wait != 3'd0) begin
                done_wait <= done_wait - 3'd1;
                if (done_wait == 3'd1) begin
                    fetch_done <= 1'b1;
                end
            end
            if (msg_gnt) begin
                msg_gnt  <= 1'b0;
                msg_wait <= r[16:15];
            end else if (msg_req) begin
                if (msg_wait == 2'd0) begin
                    msg_gnt <= 1'b1;
                end else begin
                    msg_wait <= msg_wait - 2'd1;
                end
            end
        end
    end

    // tracks the steps of the request in service
    always @(posedge clk) begin
        if (rst_n) begin
            if (acc_req && acc_gnt) begin
                if (!looked) begin
                    exp_status[n_done] <= acc_status;
                    looked             <= 1'b1;
                end else begin
                    updated <= 1'b1;
                end
            end
            if (fetch_req && fetch_gnt) begin
                fetched <= 1'b1;
            end
            if (fetch_done) begin
                wb_done <= 1'b1;
            end
            if (msg_req && msg_gnt) begin
                n_done            <= n_done + 6'd1;
                done_cnt[head_ta] <= done_cnt[head_ta] + 6'd1;
                looked            <= 1'b0;
                updated           <= 1'b0;
                fetched           <= 1'b0;
                wb_done           <= 1'b0;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || !rst_q) |-> !(acc_req || fetch_req || msg_req))
        else report_mismatch("reset_quiet", "000", $sformatf("%b%b%b",
            $sampled(acc_req), $sampled(fetch_req), $sampled(msg_req)));

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (n_sent == n_done) |-> !(acc_req || fetch_req || msg_req))
        else abort_run("request raised with no request to this cache outstanding");

    a_acc_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        acc_req |-> acc_cmd == exp_acc_cmd)
        else report_mismatch("access_cmd", $sformatf("%0d", $sampled(exp_acc_cmd)),
            $sformatf("%0d", $sampled(acc_cmd)));

    a_acc_index: assert property (@(posedge clk) disable iff (!rst_n)
        acc_req |-> acc_index == head_idx)
        else report_mismatch("access_index", $sformatf("%h", $sampled(head_idx)),
            $sformatf("%h", $sampled(acc_index)));

    a_update_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        acc_req && looked |-> !updated && !exp_absent && (!exp_dirty || wb_done))
        else abort_run("update access for an absent line, a second time or before fetch_done");

    a_fetch_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |-> looked && exp_dirty && !fetched)
        else abort_run("writeback requested for a line that was not looked up as dirty");

    a_fetch_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |-> fetch_cmd == coh_pkg::fcmd_writeback)
        else report_mismatch("fetch_cmd", $sformatf("%0d", coh_pkg::fcmd_writeback),
            $sformatf("%0d", $sampled(fetch_cmd)));

    a_fetch_addr: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req |-> fetch_addr == head_idx)
        else report_mismatch("fetch_addr", $sformatf("%h", $sampled(head_idx)),
            $sformatf("%h", $sampled(fetch_addr)));

    a_rsp_ready: assert property (@(posedge clk) disable iff (!rst_n)
        msg_req |-> looked && (exp_absent || updated))
        else abort_run("response sent before the lookup and update were done");

    a_rsp_word: assert property (@(posedge clk) disable iff (!rst_n)
        msg_req |-> msg == exp_rsp)
        else report_mismatch("response_word", $sformatf("%h", $sampled(exp_rsp)),
            $sformatf("%h", $sampled(msg)));

    a_msg_hold: assert property (@(posedge clk) disable iff (!rst_n)
        msg_req && !msg_gnt |=> msg_req && $stable(msg))
        else abort_run("response dropped or changed while waiting for msg_gnt");

    initial begin
        while (n_done != num_reqs && cycle_cnt != max_cycles) begin
            @(posedge clk);
        end
        if (n_done == num_reqs) begin
            repeat (5) @(posedge clk); // let the last pop settle
            $display("TEST OK");
            $finish;
        end else begin
            abort_run($sformatf("run hung: %0d of %0d requests answered after %0d cycles",
                n_done, num_reqs, cycle_cnt));
        end
    end

endmodule
